/* awgn_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module awgn_ctrl (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic run,
	input  wire logic [snr_pkg::snr_width-1:0] snr_db,
	input  wire logic snr_load,
	output logic step,
	output logic [snr_pkg::sigma_width-1:0] sigma,
	output logic sample_valid,
	output logic snr_err
);

	logic [snr_pkg::snr_width-1:0] snr_idx;
	logic [awgn_pkg::pipe_depth-1:0] valid_sr;
	logic snr_bad;

	// Bank steps only while running
	assign step = run;

	////////////////////////////////////////////////////////////////////////////
	// SNR register and range check
	////////////////////////////////////////////////////////////////////////////
	assign snr_bad = (snr_db > snr_pkg::snr_max);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			snr_idx <= '0;
			snr_err <= 1'b0;
		end else begin
			snr_err <= snr_load && snr_bad;
			// Out of range values keep the old setting
			if (snr_load && !snr_bad)
				snr_idx <= snr_db;
		end
	end

	assign sigma = snr_pkg::sigma_table[snr_idx];

	////////////////////////////////////////////////////////////////////////////
	// Valid tracking
	////////////////////////////////////////////////////////////////////////////
	// One stage per pipeline register: bank, sum, quant, product
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_sr <= '0;
		else
			valid_sr <= {valid_sr[awgn_pkg::pipe_depth-2:0], run};
	end

	assign sample_valid = valid_sr[awgn_pkg::pipe_depth-1];

	a_snr_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		snr_idx <= snr_pkg::snr_max
	);

	a_err_after_load: assert property (
		@(posedge clk) disable iff (!rst_n)
		snr_err |-> $past(snr_load)
	);

endmodule

`default_nettype wire

/* awgn_gen.f */
awgn_pkg.sv
snr_pkg.sv
awgn_ctrl.sv
uniform_bank.sv
clt_sum.sv
noise_scale.sv
awgn_gen.sv
awgn_gen_checker.sv
awgn_gen_tb.sv

/* awgn_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module awgn_gen (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic run,
	input  wire logic [snr_pkg::snr_width-1:0] snr_db,
	input  wire logic snr_load,
	output logic signed [awgn_pkg::sample_width-1:0] awgn_out,
	output logic signed [awgn_pkg::quant_width-1:0] awgn_out_quant,
	output logic signed [snr_pkg::noise_width-1:0] noise_out,
	output logic sample_valid,
	output logic snr_err
);

	logic step;
	logic [snr_pkg::sigma_width-1:0] sigma;
	logic [awgn_pkg::num_sources-1:0][awgn_pkg::uniform_width-1:0] uniform_words;

	awgn_ctrl awgn_ctrl_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.run          (run),
		.snr_db       (snr_db),
		.snr_load     (snr_load),
		.step         (step),
		.sigma        (sigma),
		.sample_valid (sample_valid),
		.snr_err      (snr_err)
	);

	uniform_bank uniform_bank_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.step          (step),
		.uniform_words (uniform_words)
	);

	// Sum word feeds both the raw output and the scaler
	clt_sum clt_sum_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.uniform_words (uniform_words),
		.sum_word      (awgn_out)
	);

	noise_scale noise_scale_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.sum_word (awgn_out),
		.sigma    (sigma),
		.quant    (awgn_out_quant),
		.noise    (noise_out)
	);

endmodule

`default_nettype wire

/* awgn_gen_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module awgn_gen_checker (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic run,
	input  wire logic [snr_pkg::snr_width-1:0] snr_db,
	input  wire logic snr_load,
	input  wire logic signed [awgn_pkg::sample_width-1:0] awgn_out,
	input  wire logic signed [awgn_pkg::quant_width-1:0] awgn_out_quant,
	input  wire logic signed [snr_pkg::noise_width-1:0] noise_out,
	input  wire logic sample_valid,
	input  wire logic snr_err,
	input  wire logic done,
	input  wire logic [31:0] exp_errs
);

	int mismatch_count = 0;
	int run_cycles = 0;
	int valid_cycles = 0;
	int err_seen = 0;

	// Model state, each holds what the DUT register should hold now
	logic [awgn_pkg::uniform_width-1:0] m_words [awgn_pkg::num_sources];
	awgn_pkg::clt_word_u m_sum;
	logic signed [awgn_pkg::quant_width-1:0] m_quant;
	logic signed [snr_pkg::noise_width-1:0] m_noise;
	logic [3:0] m_valid_sr;
	logic [snr_pkg::snr_width-1:0] m_snr_idx;
	logic m_err;

	task automatic check_value(input string name, input longint expected, input longint actual);
		if (expected != actual) begin
			mismatch_count++;
			$display("MISMATCH at %0t ns: %s expected %0d, actual %0d",
				$time, name, expected, actual);
		end
	endtask

	// Floor of q times sigma over 2^16, toward minus infinity
	function automatic int scaled_noise(input int q, input int sigma);
		int p;
		p = q * sigma;
		if (p >= 0)
			return p / 65536;
		return -((65535 - p) / 65536);
	endfunction

	function automatic logic signed [31:0] expected_sum();
		longint total;
		total = 0;
		for (int i = 0; i < awgn_pkg::num_sources; i++)
			total += m_words[i];
		return 32'(total - longint'(awgn_pkg::clt_offset));
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Cycle model, compared mid-cycle while the outputs are stable
	////////////////////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < awgn_pkg::num_sources; i++)
				m_words[i] = awgn_pkg::lfsr_seeds[i];
			m_sum.sample = '0;
			m_quant = '0;
			m_noise = '0;
			m_valid_sr = '0;
			m_snr_idx = '0;
			m_err = 1'b0;
		end
		check_value("awgn_out", m_sum.sample, awgn_out);
		check_value("awgn_out_quant", m_quant, awgn_out_quant);
		check_value("noise_out", m_noise, noise_out);
		check_value("sample_valid", m_valid_sr[3], sample_valid);
		check_value("snr_err", m_err, snr_err);
		if (rst_n) begin
			run_cycles += int'(run);
			valid_cycles += int'(sample_valid);
			err_seen += int'(snr_err);
			// Next edge, later pipeline stages first
			m_noise = 8'(scaled_noise(m_quant, int'(snr_pkg::sigma_table[m_snr_idx])));
			m_quant = m_sum.fields.q;
			m_sum.sample = expected_sum();
			m_valid_sr = {m_valid_sr[2:0], run};
			m_err = snr_load && (snr_db > snr_pkg::snr_max);
			if (snr_load && !m_err)
				m_snr_idx = snr_db;
			if (run) begin
				for (int i = 0; i < awgn_pkg::num_sources; i++)
					m_words[i] = (m_words[i] >> 1)
						^ (m_words[i][0] ? awgn_pkg::lfsr_taps : '0);
			end
		end
	end

	// One valid sample per run cycle, one error pulse per bad load
	always @(posedge done) begin
		check_value("sample_valid count", run_cycles, valid_cycles);
		check_value("snr_err pulse count", exp_errs, err_seen);
	end

endmodule

`default_nettype wire

/* awgn_gen_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module awgn_gen_tb;

	localparam int reset_cycles = 10;
	localparam int num_rows = 15;
	localparam int drain_cycles = 8;

	// SNR setting, load flag, run length, idle length, expected error
	typedef struct {
		logic [snr_pkg::snr_width-1:0] snr;
		bit load;
		int run_len;
		int idle_len;
		bit err;
	} row_t;

	row_t rows [num_rows] = '{
		'{4'd0, 1'b1, 6, 3, 1'b0},
		'{4'd1, 1'b1, 5, 4, 1'b0},
		'{4'd2, 1'b1, 8, 2, 1'b0},
		'{4'd3, 1'b1, 3, 5, 1'b0},
		'{4'd4, 1'b1, 12, 3, 1'b0},
		'{4'd5, 1'b1, 4, 2, 1'b0},
		'{4'd11, 1'b1, 6, 3, 1'b1},
		'{4'd6, 1'b1, 7, 4, 1'b0},
		'{4'd7, 1'b1, 5, 2, 1'b0},
		'{4'd15, 1'b1, 5, 3, 1'b1},
		'{4'd8, 1'b1, 9, 3, 1'b0},
		'{4'd9, 1'b1, 4, 6, 1'b0},
		'{4'd13, 1'b0, 6, 2, 1'b0},
		'{4'd10, 1'b1, 10, 4, 1'b0},
		'{4'd0, 1'b0, 12, 5, 1'b0}
	};

	logic clk = 1'b0;
	logic rst_n;
	logic run;
	logic [snr_pkg::snr_width-1:0] snr_db;
	logic snr_load;
	logic signed [awgn_pkg::sample_width-1:0] awgn_out;
	logic signed [awgn_pkg::quant_width-1:0] awgn_out_quant;
	logic signed [snr_pkg::noise_width-1:0] noise_out;
	logic sample_valid;
	logic snr_err;
	logic done;
	logic [31:0] exp_errs;
	logic [31:0] rng_state = 32'hb0f0_b81d;
	int extra_idle [num_rows];
	int cycle_count = 0;
	int cycle_limit = 0;

	always #4 clk = ~clk;

	awgn_gen awgn_gen_i (.*);

	awgn_gen_checker checker_i (.*);

	// Right shifting Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr32_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	task automatic draw_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | int'(rng_state[0]);
			rng_state = lfsr32_next(rng_state);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// Load strobe, then the burst, then the idle gap
	task automatic apply_row(input row_t r, input int extra);
		snr_db = r.snr;
		snr_load = r.load;
		next_cycle();
		snr_load = 1'b0;
		run = 1'b1;
		repeat (r.run_len) next_cycle();
		run = 1'b0;
		repeat (r.idle_len + extra) next_cycle();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////
	initial begin
		rst_n = 1'b0;
		run = 1'b0;
		snr_db = '0;
		snr_load = 1'b0;
		done = 1'b0;
		exp_errs = '0;
		cycle_limit = reset_cycles + drain_cycles + 2 + 50;
		for (int i = 0; i < num_rows; i++) begin
			draw_bits(2, extra_idle[i]);
			cycle_limit += 1 + rows[i].run_len + rows[i].idle_len + extra_idle[i];
			exp_errs += 32'(rows[i].err);
		end
		repeat (reset_cycles) next_cycle();
		rst_n = 1'b1;
		next_cycle();
		for (int i = 0; i < num_rows; i++)
			apply_row(rows[i], extra_idle[i]);
		repeat (drain_cycles) next_cycle();
		done = 1'b1;
		next_cycle();
		$display("Error counts: %0d mismatches over %0d valid samples",
			checker_i.mismatch_count, checker_i.valid_cycles);
		if (checker_i.mismatch_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* awgn_pkg.sv */
`default_nettype none

package awgn_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////////////////////
	localparam int unsigned uniform_width = 28;
	localparam int unsigned num_sources = 12;
	localparam int unsigned sample_width = 32;
	localparam int unsigned quant_width = 7;

	// Run to sample_valid latency in cycles
	localparam int unsigned pipe_depth = 4;

	// Twelve times half of the largest uniform word
	localparam logic [sample_width-1:0] clt_offset = 32'd1610612730;

	////////////////////////////////////////////////////////////////////////////
	// LFSR bank constants
	////////////////////////////////////////////////////////////////////////////
	// x^28 + x^25 + 1, right shifting Galois form
	localparam logic [uniform_width-1:0] lfsr_taps = 28'h900_0000;

	localparam logic [uniform_width-1:0] lfsr_seeds [num_sources] = '{
		28'h5a3_c1e7, 28'hb24_d091, 28'h13f_8a26, 28'hc7e_0453,
		28'h2d9_1b6e, 28'h8f0_372c, 28'h46a_c5d9, 28'he15_b8f0,
		28'h7bd_2140, 28'h39e_6ca5, 28'hd08_f73b, 28'h6c4_a2e8
	};

	// Quantized view of the sum, top bits plus the dropped fraction
	typedef struct packed {
		logic signed [quant_width-1:0] q;
		logic [sample_width-quant_width-1:0] frac;
	} clt_fields_s;

	typedef union packed {
		logic signed [sample_width-1:0] sample;
		clt_fields_s fields;
	} clt_word_u;

endpackage

`default_nettype wire

/* clt_sum.sv */
`timescale 1ns/1ns
`default_nettype none

module clt_sum (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic [awgn_pkg::num_sources-1:0][awgn_pkg::uniform_width-1:0] uniform_words,
	output awgn_pkg::clt_word_u sum_word
);

	logic [awgn_pkg::sample_width-1:0] word_total;

	////////////////////////////////////////////////////////////////////////////
	// Central limit sum
	////////////////////////////////////////////////////////////////////////////
	// Twelve 28 bit words stay below 2^32, no overflow
	always_comb begin
		word_total = '0;
		for (int i = 0; i < awgn_pkg::num_sources; i++)
			word_total = word_total
				+ {{(awgn_pkg::sample_width-awgn_pkg::uniform_width){1'b0}}, uniform_words[i]};
	end

	// Removing the mean centres the sample on zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sum_word.sample <= '0;
		else
			sum_word.sample <= $signed(word_total - awgn_pkg::clt_offset);
	end

endmodule

`default_nettype wire

/* noise_scale.sv */
`timescale 1ns/1ns
`default_nettype none

module noise_scale (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire awgn_pkg::clt_word_u sum_word,
	input  wire logic [snr_pkg::sigma_width-1:0] sigma,
	output logic signed [awgn_pkg::quant_width-1:0] quant,
	output logic signed [snr_pkg::noise_width-1:0] noise
);

	localparam int unsigned prod_width = awgn_pkg::quant_width + snr_pkg::sigma_width + 1;

	logic signed [prod_width-1:0] product;
	logic signed [prod_width-1:0] scaled;

	////////////////////////////////////////////////////////////////////////////
	// Quantizer stage
	////////////////////////////////////////////////////////////////////////////
	// Keep bits 31 to 25 of the sample
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			quant <= '0;
		else
			quant <= sum_word.fields.q;
	end

	////////////////////////////////////////////////////////////////////////////
	// Deviation multiply
	////////////////////////////////////////////////////////////////////////////
	// Zero bit on sigma keeps the Q0.16 word positive
	assign product = quant * $signed({1'b0, sigma});

	// Arithmetic shift floors toward minus infinity
	assign scaled = product >>> snr_pkg::sigma_frac_bits;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			noise <= '0;
		else
			noise <= scaled[snr_pkg::noise_width-1:0];
	end

	a_noise_fits: assert property (
		@(posedge clk) disable iff (!rst_n)
		(scaled >= -(2 ** (snr_pkg::noise_width - 1)))
			&& (scaled <= (2 ** (snr_pkg::noise_width - 1)) - 1)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module awgn_gen_tb -f awgn_gen.f -o awgn_gen_sim

./obj_dir/awgn_gen_sim | tee sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
	echo "run_sim: test passed"
else
	echo "run_sim: test failed"
	exit 1
fi

/* snr_pkg.sv */
`default_nettype none

package snr_pkg;

	////////////////////////////////////////////////////////////////////////////
	// SNR setting
	////////////////////////////////////////////////////////////////////////////
	localparam int unsigned snr_width = 4;

	// Highest legal setting in dB
	localparam int unsigned snr_max = 10;

	////////////////////////////////////////////////////////////////////////////
	// Noise deviation, unsigned Q0.16
	////////////////////////////////////////////////////////////////////////////
	localparam int unsigned sigma_width = 16;
	localparam int unsigned sigma_frac_bits = 16;

	// Index is the SNR in dB, 0 dB first
	localparam logic [sigma_width-1:0] sigma_table [snr_max+1] = '{
		16'd8192,
		16'd7301,
		16'd6508,
		16'd5800,
		16'd5171,
		16'd4607,
		16'd4103,
		16'd3657,
		16'd3264,
		16'd2910,
		16'd2589
	};

	// Signed scaled noise output
	localparam int unsigned noise_width = 8;

endpackage

`default_nettype wire

/* uniform_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module uniform_bank (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic step,
	output logic [awgn_pkg::num_sources-1:0][awgn_pkg::uniform_width-1:0] uniform_words
);

	logic [awgn_pkg::num_sources-1:0][awgn_pkg::uniform_width-1:0] next_words;

	////////////////////////////////////////////////////////////////////////////
	// Galois feedback
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < awgn_pkg::num_sources; i++) begin
			// Shift right, fold taps back in when bit 0 falls out
			if (uniform_words[i][0])
				next_words[i] = (uniform_words[i] >> 1) ^ awgn_pkg::lfsr_taps;
			else
				next_words[i] = uniform_words[i] >> 1;
		end
	end

	// State registers double as the bank outputs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < awgn_pkg::num_sources; i++)
				uniform_words[i] <= awgn_pkg::lfsr_seeds[i];
		end else if (step) begin
			uniform_words <= next_words;
		end
	end

	// A zero state would lock up the source
	for (genvar g = 0; g < awgn_pkg::num_sources; g++) begin : g_chk
		a_never_zero: assert property (
			@(posedge clk) disable iff (!rst_n)
			uniform_words[g] != '0
		);
	end

endmodule

`default_nettype wire
